/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // word read request held until its response
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } bus_req_t;

  // read response valid for one cycle
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } bus_rsp_t;

  // control transfer opcodes
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // integer loads
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  // fence.i with rd, rs1 and imm all zero
  localparam logic [31:0] INST_FENCE_I = 32'h0000100f;

  localparam logic [31:0] PC_RESET = 32'h00000000;

endpackage

`default_nettype wire

/* verilog/word_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module word_mem #(
  parameter int MEM_AW = 8
) (
  input  wire logic                clk,
  input  wire fetch_pkg::bus_req_t req_i,
  output fetch_pkg::bus_rsp_t      rsp_o,
  input  wire logic                we_i,
  input  wire logic [MEM_AW-1:0]   waddr_i,
  input  wire logic [31:0]         wdata_i
);

  logic [31:0] mem_q [2**MEM_AW];
  logic [MEM_AW-1:0] raddr;

  // byte address to word index
  assign raddr = req_i.addr[MEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
    rsp_o.valid <= req_i.valid;
    if (req_i.valid) begin
      rsp_o.data <= mem_q[raddr];
    end
  end

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire fetch_pkg::bus_req_t ld_req_i,
  input  wire fetch_pkg::bus_req_t if_req_i,
  output fetch_pkg::bus_req_t      mem_req_o,
  input  wire fetch_pkg::bus_rsp_t mem_rsp_i,
  output fetch_pkg::bus_rsp_t      ld_rsp_o,
  output fetch_pkg::bus_rsp_t      if_rsp_o
);

  logic busy_q;
  // high when the load port holds the grant
  logic owner_ld_q;
  logic grant_ld;

  // loads win over cache fills
  assign grant_ld = ld_req_i.valid;

  always_comb begin
    mem_req_o = grant_ld ? ld_req_i : if_req_i;
    // one request in flight at a time
    if (busy_q) begin
      mem_req_o.valid = 1'b0;
    end
  end

  always_comb begin
    ld_rsp_o = mem_rsp_i;
    if_rsp_o = mem_rsp_i;
    ld_rsp_o.valid = mem_rsp_i.valid && busy_q && owner_ld_q;
    if_rsp_o.valid = mem_rsp_i.valid && busy_q && !owner_ld_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      owner_ld_q <= 1'b0;
    end else if (!busy_q) begin
      if (mem_req_o.valid) begin
        busy_q <= 1'b1;
        owner_ld_q <= grant_ld;
      end
    end else if (mem_rsp_i.valid) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/load_port.sv */
`timescale 1ns/1ps
`default_nettype none

module load_port (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                ld_req_i,
  input  wire logic [31:0]         ld_addr_i,
  output logic                     ld_valid_o,
  output logic [31:0]              ld_data_o,
  output logic                     ld_busy_o,
  output fetch_pkg::bus_req_t      req_o,
  input  wire fetch_pkg::bus_rsp_t rsp_i
);

  logic busy_q;
  logic [31:0] addr_q;
  logic start;

  // requests while busy are dropped
  assign start = ld_req_i && !busy_q;

  assign req_o.valid = busy_q;
  assign req_o.addr = addr_q;

  assign ld_valid_o = busy_q && rsp_i.valid;
  assign ld_data_o = rsp_i.data;
  assign ld_busy_o = busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else if (start) begin
      busy_q <= 1'b1;
    end else if (rsp_i.valid) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= ld_addr_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/l1i_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l1i_cache #(
  parameter int IDX_W = 2
) (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic [31:0]         pc_i,
  input  wire logic                flush_i,
  output logic                     hit_o,
  output logic [31:0]              inst_o,
  output fetch_pkg::bus_req_t      req_o,
  input  wire fetch_pkg::bus_rsp_t rsp_i
);

  localparam int LINES = 2 ** IDX_W;
  localparam int TAG_W = 32 - IDX_W - 3;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_W0,
    FILL_W1
  } fill_state_t;

  fill_state_t state_q;
  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q [LINES];
  logic [31:0] data_q [LINES][2];
  // pc[31:3] of the line being filled
  logic [28:0] fill_line_q;

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic [IDX_W-1:0] fill_idx;

  assign idx = pc_i[IDX_W+2:3];
  assign tag = pc_i[31:IDX_W+3];
  assign fill_idx = fill_line_q[IDX_W-1:0];

  // lookup is purely combinational on the current pc
  assign hit_o = valid_q[idx] && (tag_q[idx] == tag);
  assign inst_o = data_q[idx][pc_i[2]];

  assign req_o.valid = (state_q != FILL_IDLE);
  assign req_o.addr = {fill_line_q, (state_q == FILL_W1), 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        FILL_IDLE: begin
          if (!hit_o) begin
            state_q <= FILL_W0;
          end
        end
        FILL_W0: begin
          if (rsp_i.valid) begin
            state_q <= FILL_W1;
          end
        end
        FILL_W1: begin
          if (rsp_i.valid) begin
            state_q <= FILL_IDLE;
            valid_q[fill_idx] <= 1'b1;
          end
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
      // fence.i drops every line
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FILL_IDLE) begin
      fill_line_q <= pc_i[31:3];
    end
    if (state_q == FILL_W0 && rsp_i.valid) begin
      data_q[fill_idx][0] <= rsp_i.data;
    end
    if (state_q == FILL_W1 && rsp_i.valid) begin
      data_q[fill_idx][1] <= rsp_i.data;
      tag_q[fill_idx] <= fill_line_q[28:IDX_W];
    end
  end

endmodule

`default_nettype wire

/* verilog/fetch_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_seq (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic [31:0] inst_i,
  input  wire logic        hit_i,
  input  wire logic        next_ready_i,
  input  wire logic        pc_change_i,
  input  wire logic [31:0] npc_i,
  input  wire logic        pc_retire_i,
  output logic [31:0]      pc_o,
  output logic             valid_o,
  output logic             flush_o
);

  logic [31:0] pc_q;
  logic stall_q;

  logic [6:0] opcode;
  logic is_ctrl;
  logic is_load;
  logic fire;

  assign opcode = inst_i[6:0];

  assign is_ctrl = (opcode == fetch_pkg::OP_JAL)
                || (opcode == fetch_pkg::OP_JALR)
                || (opcode == fetch_pkg::OP_BRANCH)
                || (opcode == fetch_pkg::OP_SYSTEM);
  assign is_load = (opcode == fetch_pkg::OP_LOAD);

  // nothing offered while waiting on the back end
  assign valid_o = hit_i && !stall_q;
  assign fire = valid_o && next_ready_i;

  assign flush_o = fire && (inst_i == fetch_pkg::INST_FENCE_I);
  assign pc_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= fetch_pkg::PC_RESET;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      // redirect wins over retire
      if (pc_change_i) begin
        pc_q <= npc_i;
        stall_q <= 1'b0;
      end else if (pc_retire_i) begin
        pc_q <= pc_q + 32'd4;
        stall_q <= 1'b0;
      end
    end else if (fire) begin
      if (is_ctrl || is_load) begin
        // pc stays on the stalled instruction
        stall_q <= 1'b1;
      end else begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
  parameter int IDX_W  = 2,
  parameter int MEM_AW = 8
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              next_ready_i,
  input  wire logic              pc_change_i,
  input  wire logic [31:0]       npc_i,
  input  wire logic              pc_retire_i,
  input  wire logic              ld_req_i,
  input  wire logic [31:0]       ld_addr_i,
  input  wire logic              pre_we_i,
  input  wire logic [MEM_AW-1:0] pre_addr_i,
  input  wire logic [31:0]       pre_data_i,
  output logic [31:0]            inst_o,
  output logic [31:0]            pc_o,
  output logic                   valid_o,
  output logic                   ld_valid_o,
  output logic [31:0]            ld_data_o,
  output logic                   ld_busy_o
);

  logic hit;
  logic flush;

  fetch_pkg::bus_req_t if_req;
  fetch_pkg::bus_req_t ld_req;
  fetch_pkg::bus_req_t mem_req;
  fetch_pkg::bus_rsp_t if_rsp;
  fetch_pkg::bus_rsp_t ld_rsp;
  fetch_pkg::bus_rsp_t mem_rsp;

  fetch_seq u_seq (
    .clk(clk), .rst(rst),
    .inst_i(inst_o), .hit_i(hit), .next_ready_i(next_ready_i),
    .pc_change_i(pc_change_i), .npc_i(npc_i), .pc_retire_i(pc_retire_i),
    .pc_o(pc_o), .valid_o(valid_o), .flush_o(flush)
  );

  l1i_cache #(.IDX_W(IDX_W)) u_l1i (
    .clk(clk), .rst(rst), .pc_i(pc_o), .flush_i(flush),
    .hit_o(hit), .inst_o(inst_o), .req_o(if_req), .rsp_i(if_rsp)
  );

  load_port u_ld (
    .clk(clk), .rst(rst), .ld_req_i(ld_req_i), .ld_addr_i(ld_addr_i),
    .ld_valid_o(ld_valid_o), .ld_data_o(ld_data_o), .ld_busy_o(ld_busy_o),
    .req_o(ld_req), .rsp_i(ld_rsp)
  );

  bus_arbiter u_arb (
    .clk(clk), .rst(rst), .ld_req_i(ld_req), .if_req_i(if_req),
    .mem_req_o(mem_req), .mem_rsp_i(mem_rsp),
    .ld_rsp_o(ld_rsp), .if_rsp_o(if_rsp)
  );

  word_mem #(.MEM_AW(MEM_AW)) u_mem (
    .clk(clk), .req_i(mem_req), .rsp_o(mem_rsp),
    .we_i(pre_we_i), .waddr_i(pre_addr_i), .wdata_i(pre_data_i)
  );

endmodule

`default_nettype wire

/* tests/tb_fetch_model.svh */
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// memory image as written through the preload port
localparam int IMG_WORDS = 2 ** MEM_AW;
logic [31:0] img [IMG_WORDS];

localparam int CLS_SEQ  = 0;
localparam int CLS_CTRL = 1;
localparam int CLS_LOAD = 2;

// higher address bits alias onto the decoded word index
function automatic int word_index(input logic [31:0] addr);
  return int'((addr >> 2) % IMG_WORDS);
endfunction

function automatic logic [31:0] word_at(input logic [31:0] addr);
  return img[word_index(addr)];
endfunction

function automatic int op_class(input logic [31:0] inst);
  logic [6:0] op;
  op = inst[6:0];
  if (op == fetch_pkg::OP_JAL || op == fetch_pkg::OP_JALR ||
      op == fetch_pkg::OP_BRANCH || op == fetch_pkg::OP_SYSTEM) begin
    return CLS_CTRL;
  end
  if (op == fetch_pkg::OP_LOAD) begin
    return CLS_LOAD;
  end
  return CLS_SEQ;
endfunction

// next pc after an ordinary instruction or a retire
function automatic logic [31:0] seq_pc(input logic [31:0] pc);
  return pc + 32'd4;
endfunction

`endif

/* tests/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

  localparam int MEM_AW = 8;
  localparam int N_XFER = 400;
  localparam int CYCLE_LIMIT = 200 * N_XFER;
  localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
  localparam logic [6:0] OP_ALU_REG = 7'b0110011;

  // back end states
  localparam int BE_RUN = 0;
  localparam int BE_BRANCH = 1;
  localparam int BE_LD_ISSUE = 2;
  localparam int BE_LD_WAIT = 3;

  logic clk;
  logic rst;
  logic next_ready;
  logic pc_change;
  logic [31:0] npc;
  logic pc_retire;
  logic ld_req;
  logic [31:0] ld_addr;
  logic pre_we;
  logic [MEM_AW-1:0] pre_addr;
  logic [31:0] pre_data;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic valid_o;
  logic ld_valid_o;
  logic [31:0] ld_data_o;
  logic ld_busy_o;

  int n_errors = 0;
  int n_xfer = 0;
  int n_loads = 0;
  int n_rewrites = 0;
  int n_cycles = 0;

  `include "tb_fetch_model.svh"

  fetch_top #(.IDX_W(2), .MEM_AW(MEM_AW)) i_dut (
    .clk(clk), .rst(rst),
    .next_ready_i(next_ready), .pc_change_i(pc_change), .npc_i(npc),
    .pc_retire_i(pc_retire), .ld_req_i(ld_req), .ld_addr_i(ld_addr),
    .pre_we_i(pre_we), .pre_addr_i(pre_addr), .pre_data_i(pre_data),
    .inst_o(inst_o), .pc_o(pc_o), .valid_o(valid_o),
    .ld_valid_o(ld_valid_o), .ld_data_o(ld_data_o), .ld_busy_o(ld_busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // mostly alu words with branches, loads and fence.i mixed in
  function automatic logic [31:0] random_word();
    int pick;
    logic [31:0] r;
    pick = $urandom % 100;
    r = $urandom;
    if (pick < 8) begin
      return {r[31:7], fetch_pkg::OP_BRANCH};
    end else if (pick < 11) begin
      return {r[31:7], fetch_pkg::OP_JAL};
    end else if (pick < 13) begin
      return {r[31:7], fetch_pkg::OP_JALR};
    end else if (pick < 14) begin
      return {r[31:7], fetch_pkg::OP_SYSTEM};
    end else if (pick < 22) begin
      return {r[31:7], fetch_pkg::OP_LOAD};
    end else if (pick < 26) begin
      return fetch_pkg::INST_FENCE_I;
    end
    return {r[31:7], r[0] ? OP_ALU_IMM : OP_ALU_REG};
  endfunction

  function automatic logic [31:0] random_addr();
    logic [31:0] r;
    r = $urandom;
    return {{(30-MEM_AW){1'b0}}, r[MEM_AW-1:0], 2'b00};
  endfunction

  always @(posedge clk) begin
    n_cycles++;
    if (n_cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d transfers done",
               n_cycles, n_xfer, N_XFER);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int be_state;
    int wait_cnt;
    int widx;
    logic holding;
    logic [31:0] held_inst;
    logic [31:0] held_pc;
    logic [31:0] exp_pc;

    void'($urandom(32'h3608));
    rst = 1'b0;
    next_ready = 1'b0;
    pc_change = 1'b0;
    npc = '0;
    pc_retire = 1'b0;
    ld_req = 1'b0;
    ld_addr = '0;
    pre_we = 1'b0;
    pre_addr = '0;
    pre_data = '0;

    // image goes in first so the first line fill reads the program
    for (int i = 0; i < IMG_WORDS; i++) begin
      @(negedge clk);
      img[i] = random_word();
      pre_we = 1'b1;
      pre_addr = i[MEM_AW-1:0];
      pre_data = img[i];
    end
    @(negedge clk);
    pre_we = 1'b0;
    rst = 1'b1;
    repeat (5) @(negedge clk);
    assert (!valid_o && !ld_valid_o && !ld_busy_o && pc_o == fetch_pkg::PC_RESET) else begin
      n_errors++;
      $display("FAILED %0t: outputs not idle after reset, pc %h", $time, pc_o);
    end
    rst = 1'b0;

    exp_pc = fetch_pkg::PC_RESET;
    be_state = BE_RUN;
    holding = 1'b0;
    wait_cnt = 0;

    while (n_xfer < N_XFER) begin
      @(negedge clk);
      pc_change = 1'b0;
      pc_retire = 1'b0;
      ld_req = 1'b0;
      pre_we = 1'b0;
      assert (pc_o == exp_pc) else begin
        n_errors++;
        $display("FAILED %0t: pc %h, expected %h", $time, pc_o, exp_pc);
      end
      if (be_state != BE_LD_WAIT) begin
        assert (!ld_busy_o && !ld_valid_o) else begin
          n_errors++;
          $display("FAILED %0t: load port active with no load pending", $time);
        end
      end

      if (be_state == BE_RUN) begin
        if (holding) begin
          assert (valid_o && inst_o == held_inst && pc_o == held_pc) else begin
            n_errors++;
            $display("FAILED %0t: offer changed under back-pressure, pc %h inst %h",
                     $time, pc_o, inst_o);
          end
        end
        holding = 1'b0;
        next_ready = (($urandom % 4) != 0);
        if (valid_o) begin
          assert (inst_o == word_at(pc_o)) else begin
            n_errors++;
            $display("FAILED %0t: inst %h at pc %h, expected %h",
                     $time, inst_o, pc_o, word_at(pc_o));
          end
          if (next_ready) begin
            n_xfer++;
            if (op_class(inst_o) == CLS_CTRL) begin
              be_state = BE_BRANCH;
              wait_cnt = $urandom % 4;
            end else if (op_class(inst_o) == CLS_LOAD) begin
              be_state = BE_LD_ISSUE;
            end else begin
              if (inst_o == fetch_pkg::INST_FENCE_I) begin
                // next word changes on the same edge as the flush
                widx = word_index(pc_o + 32'd4);
                img[widx] = random_word();
                pre_we = 1'b1;
                pre_addr = widx[MEM_AW-1:0];
                pre_data = img[widx];
                n_rewrites++;
              end
              exp_pc = seq_pc(exp_pc);
            end
          end else begin
            holding = 1'b1;
            held_inst = inst_o;
            held_pc = pc_o;
          end
        end
      end else begin
        assert (!valid_o) else begin
          n_errors++;
          $display("FAILED %0t: valid_o high while stalled at pc %h", $time, pc_o);
        end
        next_ready = (($urandom % 2) == 0);
        case (be_state)
          BE_BRANCH: begin
            if (wait_cnt == 0) begin
              npc = random_addr();
              pc_change = 1'b1;
              exp_pc = npc;
              be_state = BE_RUN;
            end else begin
              wait_cnt--;
            end
          end
          BE_LD_ISSUE: begin
            ld_addr = random_addr();
            ld_req = 1'b1;
            n_loads++;
            be_state = BE_LD_WAIT;
          end
          default: begin
            assert (ld_busy_o) else begin
              n_errors++;
              $display("FAILED %0t: ld_busy_o low before the load returned", $time);
            end
            if (ld_valid_o) begin
              assert (ld_data_o == word_at(ld_addr)) else begin
                n_errors++;
                $display("FAILED %0t: load %h returned %h, expected %h",
                         $time, ld_addr, ld_data_o, word_at(ld_addr));
              end
              pc_retire = 1'b1;
              exp_pc = seq_pc(exp_pc);
              be_state = BE_RUN;
            end
          end
        endcase
      end
    end

    $display("transfers %0d  loads %0d  rewrites %0d  errors %0d",
             n_xfer, n_loads, n_rewrites, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+tests
verilog/fetch_pkg.sv
verilog/word_mem.sv
verilog/bus_arbiter.sv
verilog/load_port.sv
verilog/l1i_cache.sv
verilog/fetch_seq.sv
verilog/fetch_top.sv
tests/tb_fetch_top.sv

/* Makefile */
TOP = tb_fetch_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): list.f verilog/*.sv tests/*.sv tests/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
